//--- source/lsu_pkg.sv
package lsu_pkg;

    // ----------------------------------------
    // widths and sizes
    // ----------------------------------------

    localparam int XLEN       = 32;
    localparam int DMEM_WORDS = 256;
    // word address into the data RAM
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);
    localparam int LSQ_DEPTH  = 4;

    // riscv width codes, loads
    localparam logic [2:0] LB  = 3'b000;
    localparam logic [2:0] LH  = 3'b001;
    localparam logic [2:0] LW  = 3'b010;
    localparam logic [2:0] LBU = 3'b100;
    localparam logic [2:0] LHU = 3'b101;
    // stores
    localparam logic [2:0] SB  = 3'b000;
    localparam logic [2:0] SH  = 3'b001;
    localparam logic [2:0] SW  = 3'b010;

    // ----------------------------------------
    // bundles
    // ----------------------------------------

    // request from the execution stage
    typedef struct packed {
        logic            is_store;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } lsu_req_t;

    // data port request, wdata low-aligned
    typedef struct packed {
        logic            is_store;
        logic [2:0]      funct3;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    // data port response, data is the bad address on an error
    typedef struct packed {
        logic            rerr;
        logic            werr;
        logic [XLEN-1:0] data;
    } mem_rsp_t;

    // per-load bookkeeping kept while in flight
    typedef struct packed {
        logic [4:0] rd;
        logic [2:0] funct3;
        logic [1:0] offset;
    } ld_ctrl_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } lsu_wb_t;

    typedef struct packed {
        logic            laf;
        logic            saf;
        logic [XLEN-1:0] badaddr;
    } lsu_fault_t;

endpackage

//--- source/lsu_fifo.sv
`timescale 1ns/100ps

module lsu_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     wr_i,
    input  payload_t din_i,
    input  logic     rd_i,
    output payload_t dout_o,
    output logic     empty_o,
    output logic     full_o
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    // head is visible without a read
    assign dout_o  = mem[rd_ptr];
    assign empty_o = (count == '0);
    assign full_o  = (count == DEPTH);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_i) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_i, rd_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // the owner gates its strobes with the flags
    assert property (@(posedge clk_i) disable iff (rst_i) wr_i |-> !full_o)
        else $error("lsu_fifo: write while full");
    assert property (@(posedge clk_i) disable iff (rst_i) rd_i |-> !empty_o)
        else $error("lsu_fifo: read while empty");

endmodule

//--- source/dmem_wait_timer.sv
`timescale 1ns/100ps

module dmem_wait_timer (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       load_i,
    input  logic [1:0] cycles_i,
    output logic       done_o
);

    logic [1:0] count;
    logic       armed;

    // one-cycle pulse once the count has run out
    assign done_o = armed & (count == 2'd0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count <= 2'd0;
            armed <= 1'b0;
        end else if (load_i) begin
            count <= cycles_i;
            armed <= 1'b1;
        end else if (armed) begin
            if (count == 2'd0) begin
                armed <= 1'b0;
            end else begin
                count <= count - 2'd1;
            end
        end
    end

endmodule

//--- source/dmem_ram.sv
`timescale 1ns/100ps

module dmem_ram
    import lsu_pkg::*;
(
    input  logic               clk_i,
    // write port
    input  logic               we_i,
    input  logic [3:0]         be_i,
    input  logic [DMEM_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]    wdata_i,
    // read port
    input  logic [DMEM_AW-1:0] raddr_i,
    output logic [XLEN-1:0]    rdata_o
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    // ----------------------------------------
    // byte-lane writes
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (be_i[lane]) begin
                    mem[waddr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
                end
            end
        end
    end

    // registered read, word is out the next cycle
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

//--- source/dmem_ctrl.sv
`timescale 1ns/100ps

module dmem_ctrl
    import lsu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    // request
    input  logic     dreq_valid_i,
    input  mem_req_t dreq_i,
    output logic     dreq_ready_o,
    // response
    output logic     drsp_valid_o,
    output mem_rsp_t drsp_o,
    input  logic     drsp_ready_i
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        ACCESS,
        READ,
        RESP
    } state_t;

    state_t             state;
    mem_req_t           req_q;
    mem_rsp_t           rsp_q;
    logic               dreq_fire;
    logic               timer_done;
    logic               in_range;
    logic               ram_we;
    logic [3:0]         be;
    logic [XLEN-1:0]    lane_data;
    logic [DMEM_AW-1:0] word_addr;
    logic [XLEN-1:0]    ram_rdata;

    assign dreq_ready_o = (state == IDLE);
    assign dreq_fire    = dreq_valid_i & dreq_ready_o;
    assign drsp_valid_o = (state == RESP);
    assign drsp_o       = rsp_q;

    // anything past the last RAM word faults
    assign in_range  = (req_q.addr[XLEN-1:DMEM_AW+2] == '0);
    assign word_addr = req_q.addr[DMEM_AW+1:2];
    assign ram_we    = (state == ACCESS) & req_q.is_store & in_range;

    // lanes from width and offset
    always_comb begin
        lane_data = req_q.wdata << {req_q.addr[1:0], 3'b000};
        case (req_q.funct3)
            SB:      be = 4'b0001 << req_q.addr[1:0];
            SH:      be = 4'b0011 << req_q.addr[1:0];
            default: be = 4'b1111;
        endcase
    end

    // ----------------------------------------
    // state machine
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (dreq_fire) state <= WAIT;
                WAIT:    if (timer_done) state <= ACCESS;
                ACCESS: begin
                    if (!in_range) begin
                        state <= RESP;
                    end else if (req_q.is_store) begin
                        // good stores finish without a response
                        state <= IDLE;
                    end else begin
                        state <= READ;
                    end
                end
                READ:    state <= RESP;
                RESP:    if (drsp_ready_i) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (dreq_fire) begin
            req_q <= dreq_i;
        end
        if (state == ACCESS && !in_range) begin
            rsp_q.rerr <= ~req_q.is_store;
            rsp_q.werr <= req_q.is_store;
            rsp_q.data <= req_q.addr;
        end
        if (state == READ) begin
            rsp_q.rerr <= 1'b0;
            rsp_q.werr <= 1'b0;
            rsp_q.data <= ram_rdata;
        end
    end

    // latency is 1 + addr[3:2] cycles in WAIT
    dmem_wait_timer u_wait_timer (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .load_i   (dreq_fire),
        .cycles_i (dreq_i.addr[3:2]),
        .done_o   (timer_done)
    );

    dmem_ram u_ram (
        .clk_i   (clk_i),
        .we_i    (ram_we),
        .be_i    (be),
        .waddr_i (word_addr),
        .wdata_i (lane_data),
        .raddr_i (word_addr),
        .rdata_o (ram_rdata)
    );

    assert property (@(posedge clk_i) disable iff (rst_i)
        (drsp_valid_o && !drsp_ready_i) |=> (drsp_valid_o && $stable(drsp_o)))
        else $error("dmem_ctrl: response changed while stalled");

endmodule

//--- source/ls_queue.sv
`timescale 1ns/100ps

module ls_queue
    import lsu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    // execution stage
    input  logic       exs_req_valid_i,
    input  lsu_req_t   exs_req_i,
    output logic       exs_full_o,
    // data port request
    output logic       dreq_valid_o,
    output mem_req_t   dreq_o,
    input  logic       dreq_ready_i,
    // data port response
    input  logic       drsp_valid_i,
    input  mem_rsp_t   drsp_i,
    output logic       drsp_ready_o,
    // register write and faults
    output logic       wb_valid_o,
    output lsu_wb_t    wb_o,
    output lsu_fault_t fault_o
);

    logic            req_wr;
    logic            req_empty;
    logic            req_full;
    lsu_req_t        req_head;
    logic            dreq_fire;
    logic            ldc_wr;
    logic            ldc_rd;
    logic            ldc_empty;
    logic            ldc_full;
    ld_ctrl_t        ldc_din;
    ld_ctrl_t        ldc_head;
    logic            rsp_accept;
    logic            rdat_wr;
    logic            rdat_empty;
    logic            rdat_full;
    logic [XLEN-1:0] rdat_head;
    logic [XLEN-1:0] ld_word;

    // ----------------------------------------
    // request side
    // ----------------------------------------

    assign exs_full_o = req_full | ldc_full;
    assign req_wr     = exs_req_valid_i & ~exs_full_o;

    // hold issue while there is no room to record a load
    assign dreq_valid_o = ~req_empty & ~ldc_full;
    assign dreq_fire    = dreq_valid_o & dreq_ready_i;

    always_comb begin
        dreq_o.is_store = req_head.is_store;
        dreq_o.funct3   = req_head.funct3;
        dreq_o.addr     = req_head.addr;
        dreq_o.wdata    = req_head.wdata;
    end

    lsu_fifo #(
        .payload_t (lsu_req_t),
        .DEPTH     (LSQ_DEPTH)
    ) u_req_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .wr_i    (req_wr),
        .din_i   (exs_req_i),
        .rd_i    (dreq_fire),
        .dout_o  (req_head),
        .empty_o (req_empty),
        .full_o  (req_full)
    );

    // load bookkeeping, recorded on issue
    assign ldc_wr = dreq_fire & ~req_head.is_store;

    always_comb begin
        ldc_din.rd     = req_head.rd;
        ldc_din.funct3 = req_head.funct3;
        ldc_din.offset = req_head.addr[1:0];
    end

    // a completed load or a load fault retires the head
    assign ldc_rd = wb_valid_o | (rsp_accept & drsp_i.rerr);

    lsu_fifo #(
        .payload_t (ld_ctrl_t),
        .DEPTH     (LSQ_DEPTH)
    ) u_ldc_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .wr_i    (ldc_wr),
        .din_i   (ldc_din),
        .rd_i    (ldc_rd),
        .dout_o  (ldc_head),
        .empty_o (ldc_empty),
        .full_o  (ldc_full)
    );

    // ----------------------------------------
    // response side
    // ----------------------------------------

    assign drsp_ready_o = ~rdat_full;
    assign rsp_accept   = drsp_valid_i & drsp_ready_o;
    // only good load data is kept
    assign rdat_wr      = rsp_accept & ~drsp_i.rerr & ~drsp_i.werr;

    lsu_fifo #(
        .payload_t (logic [XLEN-1:0]),
        .DEPTH     (LSQ_DEPTH)
    ) u_rdat_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .wr_i    (rdat_wr),
        .din_i   (drsp_i.data),
        .rd_i    (wb_valid_o),
        .dout_o  (rdat_head),
        .empty_o (rdat_empty),
        .full_o  (rdat_full)
    );

    // register port never stalls
    assign wb_valid_o = ~rdat_empty;

    always_comb begin
        ld_word = rdat_head >> {ldc_head.offset, 3'b000};
        wb_o.rd = ldc_head.rd;
        case (ldc_head.funct3)
            LB:      wb_o.data = {{(XLEN-8){ld_word[7]}}, ld_word[7:0]};
            LH:      wb_o.data = {{(XLEN-16){ld_word[15]}}, ld_word[15:0]};
            LBU:     wb_o.data = {{(XLEN-8){1'b0}}, ld_word[7:0]};
            LHU:     wb_o.data = {{(XLEN-16){1'b0}}, ld_word[15:0]};
            default: wb_o.data = ld_word;
        endcase
    end

    always_comb begin
        fault_o.laf     = rsp_accept & drsp_i.rerr;
        fault_o.saf     = rsp_accept & drsp_i.werr;
        fault_o.badaddr = drsp_i.data;
    end

    // every load response needs an issued load behind it
    assert property (@(posedge clk_i) disable iff (rst_i)
        (drsp_valid_i && !drsp_i.werr) |-> !ldc_empty)
        else $error("ls_queue: load response with no load in flight");

endmodule

//--- source/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    // execution stage
    input  logic       exs_req_valid_i,
    input  lsu_req_t   exs_req_i,
    output logic       exs_full_o,
    // register write and faults
    output logic       wb_valid_o,
    output lsu_wb_t    wb_o,
    output lsu_fault_t fault_o
);

    // data port between queue and memory
    logic     dreq_valid;
    mem_req_t dreq;
    logic     dreq_ready;
    logic     drsp_valid;
    mem_rsp_t drsp;
    logic     drsp_ready;

    ls_queue u_ls_queue (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .exs_req_valid_i (exs_req_valid_i),
        .exs_req_i       (exs_req_i),
        .exs_full_o      (exs_full_o),
        .dreq_valid_o    (dreq_valid),
        .dreq_o          (dreq),
        .dreq_ready_i    (dreq_ready),
        .drsp_valid_i    (drsp_valid),
        .drsp_i          (drsp),
        .drsp_ready_o    (drsp_ready),
        .wb_valid_o      (wb_valid_o),
        .wb_o            (wb_o),
        .fault_o         (fault_o)
    );

    dmem_ctrl u_dmem_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dreq_valid_i (dreq_valid),
        .dreq_i       (dreq),
        .dreq_ready_o (dreq_ready),
        .drsp_valid_o (drsp_valid),
        .drsp_o       (drsp),
        .drsp_ready_i (drsp_ready)
    );

endmodule

//--- dv/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb
    import lsu_pkg::*;
();

    localparam string TRACE_FILE = "dv/lsu_trace.txt";

    logic       clk_i;
    logic       rst_i;
    logic       exs_req_valid_i;
    lsu_req_t   exs_req_i;
    logic       exs_full_o;
    logic       wb_valid_o;
    lsu_wb_t    wb_o;
    lsu_fault_t fault_o;

    // requests from the trace in issue order
    lsu_req_t   ops[$];
    bit         op_gap[$];
    // results come back in issue order
    lsu_wb_t    wb_exp[$];
    string      wb_names[$];
    lsu_fault_t fault_exp[$];
    string      fault_names[$];

    logic [15:0] lfsr_state = 16'd84;
    int          cycle_count = 0;
    int          timeout_cycles = 200;
    int          full_cycles = 0;

    lsu_top u_lsu_top (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .exs_req_valid_i (exs_req_valid_i),
        .exs_req_i       (exs_req_i),
        .exs_full_o      (exs_full_o),
        .wb_valid_o      (wb_valid_o),
        .wb_o            (wb_o),
        .fault_o         (fault_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #10 clk_i = ~clk_i;
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_wb(input string name, input lsu_wb_t exp, input lsu_wb_t act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s: expected rd=%0d data=%h, actual rd=%0d data=%h",
                                name, exp.rd, exp.data, act.rd, act.data));
        end
    endtask

    task automatic check_fault(input string name, input lsu_fault_t exp, input lsu_fault_t act);
        if (act !== exp) begin
            abort_run($sformatf(
                "MISMATCH %s: expected laf=%b saf=%b addr=%h, actual laf=%b saf=%b addr=%h",
                name, exp.laf, exp.saf, exp.badaddr, act.laf, act.saf, act.badaddr));
        end
    endtask

    // galois lfsr with taps at 16 14 13 11
    function automatic bit next_rand_bit();
        bit lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return lsb;
    endfunction

    // 1 to 4 idle cycles before a request
    function automatic int rand_gap();
        int gap;
        gap = 1;
        for (int i = 0; i < 2; i++) begin
            gap = gap + (int'(next_rand_bit()) << i);
        end
        return gap;
    endfunction

    task automatic read_trace();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] st;
        logic [31:0] f3;
        logic [31:0] rd;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] res;
        logic [31:0] exp_val;
        logic [31:0] gap;
        lsu_req_t    req;
        lsu_wb_t     wb;
        lsu_fault_t  flt;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the trace file");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %s",
                        st, f3, rd, addr, wdata, res, exp_val, gap, name);
            if (n != 9) begin
                abort_run($sformatf("trace line could not be parsed: %s", line));
            end
            req.is_store = st[0];
            req.funct3   = f3[2:0];
            req.rd       = rd[4:0];
            req.addr     = addr;
            req.wdata    = wdata;
            ops.push_back(req);
            op_gap.push_back(gap[0]);
            if (res == 1) begin
                wb.rd   = rd[4:0];
                wb.data = exp_val;
                wb_exp.push_back(wb);
                wb_names.push_back(name);
            end else if (res == 2 || res == 3) begin
                flt.laf     = (res == 2);
                flt.saf     = (res == 3);
                flt.badaddr = exp_val;
                fault_exp.push_back(flt);
                fault_names.push_back(name);
            end
        end
        $fclose(fd);
        timeout_cycles = 200 + 20 * ops.size();
    endtask

    // request stays up until an edge where the queue has room
    task automatic send_request(input lsu_req_t req, input bit with_gap);
        int gap;
        if (with_gap) begin
            gap = rand_gap();
            exs_req_valid_i <= 1'b0;
            repeat (gap) @(posedge clk_i);
        end
        exs_req_valid_i <= 1'b1;
        exs_req_i       <= req;
        @(negedge clk_i);
        while (exs_full_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
    endtask

    // ----------------------------------------
    // monitors
    // ----------------------------------------

    // outputs are settled mid-cycle
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (exs_full_o) begin
                full_cycles++;
            end
            if (wb_valid_o) begin
                if (wb_exp.size() == 0) begin
                    abort_run($sformatf("write-back to x%0d when none was expected", wb_o.rd));
                end else begin
                    check_wb(wb_names.pop_front(), wb_exp.pop_front(), wb_o);
                end
            end
            if (fault_o.laf || fault_o.saf) begin
                if (fault_exp.size() == 0) begin
                    abort_run($sformatf("fault at %h when none was expected", fault_o.badaddr));
                end else begin
                    check_fault(fault_names.pop_front(), fault_exp.pop_front(), fault_o);
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            abort_run("timeout: not all expected results arrived in time");
        end
    end

    initial begin
        rst_i           = 1'b1;
        exs_req_valid_i = 1'b0;
        exs_req_i       = '0;
        read_trace();
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        if (wb_valid_o || fault_o.laf || fault_o.saf || exs_full_o) begin
            abort_run("outputs were not idle after reset");
        end
        @(posedge clk_i);
        foreach (ops[i]) begin
            send_request(ops[i], op_gap[i]);
        end
        exs_req_valid_i <= 1'b0;
        while (wb_exp.size() != 0 || fault_exp.size() != 0) begin
            @(posedge clk_i);
        end
        // window for stray results
        repeat (20) @(posedge clk_i);
        if (full_cycles == 0) begin
            abort_run("the request queue never filled during the back-to-back burst");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- dv/lsu_trace.txt
# store funct3 rd addr wdata result expected gap name (all hex except name)
# store 1=store, result 0=none 1=write-back 2=load fault 3=store fault, gap 0=back-to-back
1 2 00 00000000 8badf00d 0 00000000 1 sw_word0
1 2 00 00000004 12345678 0 00000000 1 sw_word1
1 2 00 00000010 cafe80ff 0 00000000 1 sw_word4
0 2 01 00000000 00000000 1 8badf00d 1 lw_word0
1 0 00 00000005 ffffffa5 0 00000000 1 sb_off1
1 0 00 00000007 00000022 0 00000000 1 sb_off3
1 0 00 00000004 0000000f 0 00000000 1 sb_off0
1 0 00 00000006 0000009c 0 00000000 1 sb_off2
1 1 00 00000002 0000c3d2 0 00000000 1 sh_off2
1 1 00 00000000 00007e81 0 00000000 1 sh_off0
0 2 02 00000004 00000000 1 229ca50f 1 lw_after_sb
0 2 03 00000000 00000000 1 c3d27e81 1 lw_after_sh
0 0 04 00000010 00000000 1 ffffffff 0 lb_off0
0 0 05 00000011 00000000 1 ffffff80 0 lb_off1
0 0 06 00000012 00000000 1 fffffffe 0 lb_off2
0 0 07 00000013 00000000 1 ffffffca 0 lb_off3
0 4 08 00000010 00000000 1 000000ff 0 lbu_off0
0 4 09 00000011 00000000 1 00000080 0 lbu_off1
0 4 0a 00000012 00000000 1 000000fe 0 lbu_off2
0 4 0b 00000013 00000000 1 000000ca 0 lbu_off3
0 1 0c 00000010 00000000 1 ffff80ff 0 lh_off0
0 1 0d 00000012 00000000 1 ffffcafe 0 lh_off2
0 5 0e 00000010 00000000 1 000080ff 0 lhu_off0
0 5 0f 00000012 00000000 1 0000cafe 0 lhu_off2
0 0 10 00000004 00000000 1 0000000f 0 lb_positive
0 1 11 00000006 00000000 1 0000229c 0 lh_positive
0 2 12 00000400 00000000 2 00000400 0 lw_fault
1 2 00 00000800 00000001 3 00000800 0 sw_fault
0 2 13 00000010 00000000 1 cafe80ff 0 lw_after_fault

//--- build.f
source/lsu_pkg.sv
source/lsu_fifo.sv
source/dmem_wait_timer.sv
source/dmem_ram.sv
source/dmem_ctrl.sv
source/ls_queue.sv
source/lsu_top.sv
dv/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the lsu testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module lsu_tb \
    -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

# the log decides pass or fail
if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
exit 1
